//--- src/rv32_settings.svh
////////////////////////////////////////
// RV32 core settings
////////////////////////////////////////

`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Data word width
`define RV_XLEN 32

// Instruction width, fixed whatever the architecture
`define RV_ILEN 32

// Integer register count, set to 16 for RV32E
`define RV_NB_REGS 32

// Register index width, as encoded in the instruction
`define RV_REG_ADDR_W 5

`endif

//--- src/rv32_isa_pkg.sv
////////////////////////////////////////
// RV32I instruction encodings
////////////////////////////////////////

package rv32_isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // ALU funct3 codes, shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    // funct7 patterns, the alternate one selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Only these exact SYSTEM words are supported
    localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    ////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_inst_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_inst_t;

    // One word, seen as R-type or I-type
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

endpackage

//--- src/rv32_core_pkg.sv
////////////////////////////////////////
// RV32 core internal types
////////////////////////////////////////

`include "rv32_settings.svh"

package rv32_core_pkg;

    // Operations of the execute unit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // One decoded operation, as issued to the execute unit
    typedef struct packed {
        alu_op_t                   op;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic                      use_imm;
        logic [`RV_XLEN-1:0]       imm;
        logic                      ecall;
        logic                      ebreak;
        logic                      illegal;
    } dec_op_t;

    // Status bus layout
    localparam int ST_ECALL   = 0;
    localparam int ST_EBREAK  = 1;
    localparam int ST_ILLEGAL = 2;
    localparam int STATUS_W   = 3;

endpackage

//--- src/rv32_issue_if.sv
////////////////////////////////////////
// Decode to execute issue link
////////////////////////////////////////

interface rv32_issue_if;

    // One-cycle strobe per decoded operation
    logic                   valid;

    // Operation payload, meaningful while valid is high
    rv32_core_pkg::dec_op_t op;

    // Decoder side
    modport dec (
        output valid,
        output op
    );

    // Execute side, accepts every valid
    modport exe (
        input valid,
        input op
    );

endinterface

//--- src/rv32_decoder.sv
////////////////////////////////////////
// RV32I decode stage
////////////////////////////////////////

`include "rv32_settings.svh"

module rv32_decoder (
    input  logic                aclk,
    input  logic                rst,
    input  logic                inst_valid,
    input  rv32_isa_pkg::inst_u inst,
    rv32_issue_if.dec           issue
);

    rv32_core_pkg::dec_op_t dec;
    logic                   alt_f7;
    logic                   bad_regs;

    // funct3 plus alternate flag to ALU operation
    function automatic rv32_core_pkg::alu_op_t alu_sel(input logic [2:0] funct3,
                                                       input logic       alt);
        case (funct3)
            rv32_isa_pkg::F3_ADD_SUB: alu_sel = alt ? rv32_core_pkg::ALU_SUB
                                                    : rv32_core_pkg::ALU_ADD;
            rv32_isa_pkg::F3_SLL:     alu_sel = rv32_core_pkg::ALU_SLL;
            rv32_isa_pkg::F3_SLT:     alu_sel = rv32_core_pkg::ALU_SLT;
            rv32_isa_pkg::F3_SLTU:    alu_sel = rv32_core_pkg::ALU_SLTU;
            rv32_isa_pkg::F3_XOR:     alu_sel = rv32_core_pkg::ALU_XOR;
            rv32_isa_pkg::F3_SRL_SRA: alu_sel = alt ? rv32_core_pkg::ALU_SRA
                                                    : rv32_core_pkg::ALU_SRL;
            rv32_isa_pkg::F3_OR:      alu_sel = rv32_core_pkg::ALU_OR;
            default:                  alu_sel = rv32_core_pkg::ALU_AND;
        endcase
    endfunction

    // Index beyond the implemented registers (RV32E)
    function automatic logic reg_oor(input logic [`RV_REG_ADDR_W-1:0] idx);
        reg_oor = (int'(idx) >= `RV_NB_REGS);
    endfunction

    ////////////////////////////////////////
    // Combinational decode
    ////////////////////////////////////////

    always_comb begin
        dec     = '0;
        dec.rs1 = inst.r.rs1;
        dec.rs2 = inst.r.rs2;
        dec.rd  = inst.r.rd;
        dec.imm = {{(`RV_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
        alt_f7  = (inst.r.funct7 == rv32_isa_pkg::F7_ALT);
        bad_regs = 1'b0;

        case (inst.r.opcode)
            rv32_isa_pkg::OP: begin
                dec.op = alu_sel(inst.r.funct3, alt_f7);
                bad_regs = reg_oor(inst.r.rs1) || reg_oor(inst.r.rs2) || reg_oor(inst.r.rd);
                // Alternate funct7 only valid for SUB and SRA
                if (inst.r.funct7 != rv32_isa_pkg::F7_BASE &&
                    !(alt_f7 && (inst.r.funct3 == rv32_isa_pkg::F3_ADD_SUB ||
                                 inst.r.funct3 == rv32_isa_pkg::F3_SRL_SRA))) begin
                    dec.illegal = 1'b1;
                end
            end
            rv32_isa_pkg::OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.rs2     = '0;
                bad_regs    = reg_oor(inst.i.rs1) || reg_oor(inst.i.rd);
                // SRAI flag lives in the funct7 position of the word
                dec.op = alu_sel(inst.i.funct3,
                                 inst.i.funct3 == rv32_isa_pkg::F3_SRL_SRA &&
                                 inst.r.funct7[5]);
                // Shift amount only, taken from the immediate field
                if (inst.i.funct3 == rv32_isa_pkg::F3_SLL ||
                    inst.i.funct3 == rv32_isa_pkg::F3_SRL_SRA) begin
                    dec.imm = {{(`RV_XLEN-5){1'b0}}, inst.i.imm12[4:0]};
                end
            end
            rv32_isa_pkg::SYSTEM: begin
                if (inst == rv32_isa_pkg::ECALL_WORD) begin
                    dec.ecall = 1'b1;
                end else if (inst == rv32_isa_pkg::EBREAK_WORD) begin
                    dec.ebreak = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            default: dec.illegal = 1'b1;
        endcase

        if (bad_regs) begin
            dec.illegal = 1'b1;
        end

        // Traps read nothing
        if (dec.ecall || dec.ebreak || dec.illegal) begin
            dec.rs1 = '0;
            dec.rs2 = '0;
        end
    end

    ////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= inst_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid) begin
            issue.op <= dec;
        end
    end

    // Trap causes are exclusive on the issue link
    assert property (@(posedge aclk) disable iff (rst)
        issue.valid |-> $onehot0({issue.op.ecall, issue.op.ebreak, issue.op.illegal}))
        else $error("decoder issued an operation with several trap flags");

endmodule

//--- src/rv32_registers.sv
////////////////////////////////////////
// RV32 integer register file
////////////////////////////////////////

`include "rv32_settings.svh"

module rv32_registers (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    output logic [`RV_XLEN-1:0]       rs1_val,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs2_val,
    input  logic                      wr_en,
    input  logic [`RV_REG_ADDR_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]       wr_val
);

    logic [`RV_XLEN-1:0] regs [`RV_NB_REGS];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NB_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_val;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // x0 is hardwired to zero
    always_comb begin
        rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
        rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    end

    // The execute unit never commits a write to x0
    assert property (@(posedge aclk) disable iff (rst)
        wr_en |-> (wr_addr != '0))
        else $error("register file write to x0");

endmodule

//--- src/rv32_alu.sv
////////////////////////////////////////
// RV32I execute stage
////////////////////////////////////////

`include "rv32_settings.svh"

module rv32_alu (
    input  logic                                aclk,
    input  logic                                rst,
    rv32_issue_if.exe                           issue,
    output logic [`RV_REG_ADDR_W-1:0]           rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0]           rs2_addr,
    input  logic [`RV_XLEN-1:0]                 rs1_val,
    input  logic [`RV_XLEN-1:0]                 rs2_val,
    output logic                                wr_en,
    output logic [`RV_REG_ADDR_W-1:0]           wr_addr,
    output logic [`RV_XLEN-1:0]                 wr_val,
    output logic                                retire_valid,
    output logic                                retire_rd_wr,
    output logic [`RV_REG_ADDR_W-1:0]           retire_rd_addr,
    output logic [`RV_XLEN-1:0]                 retire_rd_val,
    output logic [rv32_core_pkg::STATUS_W-1:0]  status
);

    logic [`RV_XLEN-1:0]               opb;
    logic [4:0]                        shamt;
    logic [`RV_XLEN-1:0]               result;
    logic                              trap;
    logic [rv32_core_pkg::STATUS_W-1:0] trap_bits;

    // Operand fetch
    assign rs1_addr = issue.op.rs1;
    assign rs2_addr = issue.op.rs2;
    assign opb      = issue.op.use_imm ? issue.op.imm : rs2_val;
    assign shamt    = opb[4:0];

    always_comb begin
        trap_bits                             = '0;
        trap_bits[rv32_core_pkg::ST_ECALL]   = issue.op.ecall;
        trap_bits[rv32_core_pkg::ST_EBREAK]  = issue.op.ebreak;
        trap_bits[rv32_core_pkg::ST_ILLEGAL] = issue.op.illegal;
    end

    assign trap = |trap_bits;

    ////////////////////////////////////////
    // Arithmetic and logic
    ////////////////////////////////////////

    always_comb begin
        case (issue.op.op)
            rv32_core_pkg::ALU_ADD:  result = rs1_val + opb;
            rv32_core_pkg::ALU_SUB:  result = rs1_val - opb;
            rv32_core_pkg::ALU_SLL:  result = rs1_val << shamt;
            rv32_core_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}},
                                               $signed(rs1_val) < $signed(opb)};
            rv32_core_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, rs1_val < opb};
            rv32_core_pkg::ALU_XOR:  result = rs1_val ^ opb;
            rv32_core_pkg::ALU_SRL:  result = rs1_val >> shamt;
            rv32_core_pkg::ALU_SRA:  result = $unsigned($signed(rs1_val) >>> shamt);
            rv32_core_pkg::ALU_OR:   result = rs1_val | opb;
            default:                 result = rs1_val & opb;
        endcase
    end

    // Write back takes effect in the register file at the next edge
    assign wr_en   = issue.valid && !trap && (issue.op.rd != '0);
    assign wr_addr = issue.op.rd;
    assign wr_val  = result;

    ////////////////////////////////////////
    // Retire outputs
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_rd_wr <= 1'b0;
            status       <= '0;
        end else begin
            retire_valid <= issue.valid;
            retire_rd_wr <= wr_en;
            status       <= issue.valid ? trap_bits : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (issue.valid) begin
            retire_rd_addr <= issue.op.rd;
            retire_rd_val  <= trap ? '0 : result;
        end
    end

    // Traps arrive with no register reads, so no index can be out of range
    assert property (@(posedge aclk) disable iff (rst)
        issue.valid && trap |-> (issue.op.rs1 == '0) && (issue.op.rs2 == '0))
        else $error("trap issued with register reads");

endmodule

//--- src/rv32_core.sv
////////////////////////////////////////
// RV32I execution core
////////////////////////////////////////

`include "rv32_settings.svh"

module rv32_core (
    input  logic                               aclk,
    input  logic                               rst,
    // Instruction input, one per cycle at most
    input  logic                               inst_valid,
    input  logic [`RV_ILEN-1:0]                inst,
    // Retire record, two cycles after acceptance
    output logic                               retire_valid,
    output logic                               retire_rd_wr,
    output logic [`RV_REG_ADDR_W-1:0]          retire_rd_addr,
    output logic [`RV_XLEN-1:0]                retire_rd_val,
    // Trap bits of the retiring instruction
    output logic [rv32_core_pkg::STATUS_W-1:0] status
);

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs2_val;
    logic                      wr_en;
    logic [`RV_REG_ADDR_W-1:0] wr_addr;
    logic [`RV_XLEN-1:0]       wr_val;

    rv32_issue_if issue ();

    ////////////////////////////////////////
    // Decode, registers, execute
    ////////////////////////////////////////

    rv32_decoder decoder (
        .aclk       (aclk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .issue      (issue.dec)
    );

    rv32_registers isa_registers (
        .aclk     (aclk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_val   (wr_val)
    );

    rv32_alu alu (
        .aclk           (aclk),
        .rst            (rst),
        .issue          (issue.exe),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_val         (wr_val),
        .retire_valid   (retire_valid),
        .retire_rd_wr   (retire_rd_wr),
        .retire_rd_addr (retire_rd_addr),
        .retire_rd_val  (retire_rd_val),
        .status         (status)
    );

endmodule

//--- verif/rv32_core_tb.sv
////////////////////////////////////////
// RV32 core testbench
////////////////////////////////////////

`include "rv32_settings.svh"

module rv32_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int N_DIRECTED = 51;
    localparam int N_RANDOM   = 400;
    // Two cycles per instruction covers random gaps and the pipeline drain
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM + 20) * CLK_PERIOD * 2;

    // funct3 codes and the alternate funct7
    localparam int F_ADD  = 0;
    localparam int F_SLL  = 1;
    localparam int F_SLT  = 2;
    localparam int F_SLTU = 3;
    localparam int F_XOR  = 4;
    localparam int F_SR   = 5;
    localparam int F_OR   = 6;
    localparam int F_AND  = 7;
    localparam int F7_ALT = 32;

    typedef struct packed {
        logic [`RV_ILEN-1:0]                word;
        logic                               rd_wr;
        logic [`RV_REG_ADDR_W-1:0]          rd;
        logic [`RV_XLEN-1:0]                val;
        logic [rv32_core_pkg::STATUS_W-1:0] status;
        logic [31:0]                        due;
    } retire_t;

    logic                               aclk = 1'b0;
    logic                               rst;
    logic                               inst_valid;
    logic [`RV_ILEN-1:0]                inst;
    logic                               retire_valid;
    logic                               retire_rd_wr;
    logic [`RV_REG_ADDR_W-1:0]          retire_rd_addr;
    logic [`RV_XLEN-1:0]                retire_rd_val;
    logic [rv32_core_pkg::STATUS_W-1:0] status;

    logic [`RV_XLEN-1:0] model_regs [32];
    retire_t             exp_q [$];
    retire_t             exp_rec;
    int                  cycle_cnt = 0;

    rv32_core UUT (
        .aclk           (aclk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .retire_valid   (retire_valid),
        .retire_rd_wr   (retire_rd_wr),
        .retire_rd_addr (retire_rd_addr),
        .retire_rd_val  (retire_rd_val),
        .status         (status)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // Rising edge count, used for retire timing
    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[ERROR] %0d ns: %s, got %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic reg_exists(input logic [4:0] idx);
        return int'(idx) < `RV_NB_REGS;
    endfunction

    function automatic retire_t model_exec(input logic [31:0] w);
        retire_t             rec;
        logic [6:0]          opc;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] res;
        logic                alt;

        rec = '0;
        rec.word = w;
        opc = w[6:0];
        rd = w[11:7];
        f3 = w[14:12];
        rs1 = w[19:15];
        rs2 = w[24:20];
        f7 = w[31:25];
        rec.rd = rd;
        a = '0;
        b = '0;
        res = '0;
        alt = 1'b0;

        if (opc == 7'b1110011) begin
            if (w == 32'h0000_0073) begin
                rec.status[rv32_core_pkg::ST_ECALL] = 1'b1;
            end else if (w == 32'h0010_0073) begin
                rec.status[rv32_core_pkg::ST_EBREAK] = 1'b1;
            end else begin
                rec.status[rv32_core_pkg::ST_ILLEGAL] = 1'b1;
            end
        end else if (opc == 7'b0110011) begin
            if (!reg_exists(rs1) || !reg_exists(rs2) || !reg_exists(rd)) begin
                rec.status[rv32_core_pkg::ST_ILLEGAL] = 1'b1;
            end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
                alt = 1'b1;
            end else if (f7 != 7'h00) begin
                rec.status[rv32_core_pkg::ST_ILLEGAL] = 1'b1;
            end
            a = model_regs[rs1];
            b = model_regs[rs2];
        end else if (opc == 7'b0010011) begin
            if (!reg_exists(rs1) || !reg_exists(rd)) begin
                rec.status[rv32_core_pkg::ST_ILLEGAL] = 1'b1;
            end
            a = model_regs[rs1];
            b = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
            // Only SRAI reads the arithmetic flag
            alt = (f3 == 3'd5) && w[30];
        end else begin
            rec.status[rv32_core_pkg::ST_ILLEGAL] = 1'b1;
        end

        if (rec.status == '0) begin
            case (f3)
                3'd0: res = alt ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res[0] = $signed(a) < $signed(b);
                3'd3: res[0] = a < b;
                3'd4: res = a ^ b;
                3'd5: begin
                    res = a >> b[4:0];
                    // Fill the vacated top bits with the sign
                    if (alt && a[`RV_XLEN-1]) begin
                        res = res | ~({`RV_XLEN{1'b1}} >> b[4:0]);
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
            rec.val = res;
            rec.rd_wr = (rd != 5'd0);
        end
        return rec;
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] r_type_word(input int f7, input int rs2, input int rs1,
                                                input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input int imm, input int rs1,
                                                input int f3, input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    // Biased to low registers so that results feed later operands
    function automatic int pick_reg();
        return ($urandom_range(0, 3) == 0) ? $urandom_range(0, 31) : $urandom_range(0, 7);
    endfunction

    function automatic logic [31:0] random_inst();
        int          pick;
        int          f3;
        int          f7;
        int          shamt;
        logic [31:0] w;

        pick = $urandom_range(0, 99);
        f3 = $urandom_range(0, 7);
        shamt = $urandom_range(0, 31);
        if (pick < 45) begin
            f7 = ((f3 == F_ADD || f3 == F_SR) && $urandom_range(0, 1) == 1) ? F7_ALT : 0;
            return r_type_word(f7, pick_reg(), pick_reg(), f3, pick_reg());
        end else if (pick < 90) begin
            if (f3 == F_SLL) begin
                return i_type_word(shamt, pick_reg(), f3, pick_reg());
            end else if (f3 == F_SR) begin
                f7 = ($urandom_range(0, 1) == 1) ? 'h400 : 0;
                return i_type_word(f7 | shamt, pick_reg(), f3, pick_reg());
            end
            return i_type_word($urandom_range(0, 4095), pick_reg(), f3, pick_reg());
        end else if (pick < 93) begin
            return 32'h0000_0073;
        end else if (pick < 95) begin
            return 32'h0010_0073;
        end else if (pick < 97) begin
            return r_type_word($urandom_range(1, 127), pick_reg(), pick_reg(), f3, pick_reg());
        end
        w = $urandom();
        case ($urandom_range(0, 3))
            0: w[6:0] = 7'b0000011;
            1: w[6:0] = 7'b0100011;
            2: w[6:0] = 7'b1100011;
            default: w[6:0] = 7'b0110111;
        endcase
        return w;
    endfunction

    task automatic send(input logic [31:0] word);
        retire_t rec;

        @(posedge aclk);
        #1;
        inst_valid = 1'b1;
        inst = word;
        rec = model_exec(word);
        // Retire is seen two edges after this one is driven
        rec.due = 32'(cycle_cnt + 2);
        exp_q.push_back(rec);
        if (rec.rd_wr) begin
            model_regs[rec.rd] = rec.val;
        end
    endtask

    // Idle cycles carry garbage on inst
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge aclk);
            #1;
            inst_valid = 1'b0;
            inst = $urandom();
        end
    endtask

    ////////////////////////////////////////
    // Directed and random tests
    ////////////////////////////////////////

    task automatic reset_state_reads();
        idle(5);
        send(r_type_word(0, 0, 1, F_ADD, 1));
        send(r_type_word(0, 0, 5, F_ADD, 5));
        send(r_type_word(0, 0, 17, F_ADD, 17));
        send(r_type_word(0, 0, 31, F_ADD, 31));
        idle(3);
    endtask

    // Back-to-back chain where each result feeds the next
    task automatic dependent_chain();
        send(i_type_word('h123, 0, F_ADD, 1));
        send(i_type_word(-5, 1, F_ADD, 2));
        send(r_type_word(0, 1, 2, F_ADD, 3));
        send(r_type_word(F7_ALT, 2, 3, F_ADD, 4));
        send(r_type_word(0, 3, 4, F_AND, 5));
        send(r_type_word(0, 4, 5, F_OR, 6));
        send(r_type_word(0, 2, 6, F_XOR, 7));
        send(i_type_word(2047, 7, F_ADD, 8));
        send(r_type_word(F7_ALT, 8, 0, F_ADD, 9));
        send(i_type_word(-2048, 9, F_ADD, 10));
        idle(2);
    endtask

    task automatic shifts_and_compares();
        send(i_type_word(-1, 0, F_ADD, 11));
        send(i_type_word(4, 0, F_ADD, 12));
        send(i_type_word(1, 0, F_ADD, 13));
        send(i_type_word(31, 13, F_SLL, 13));
        send(r_type_word(0, 12, 11, F_SLL, 14));
        send(r_type_word(0, 12, 13, F_SR, 15));
        send(r_type_word(F7_ALT, 12, 13, F_SR, 16));
        send(i_type_word('h400 | 7, 11, F_SR, 17));
        send(i_type_word('h400 | 31, 13, F_SR, 18));
        send(i_type_word(31, 13, F_SR, 19));
        // Amount 35 keeps only its low 5 bits
        send(i_type_word(35, 0, F_ADD, 20));
        send(r_type_word(0, 20, 1, F_SLL, 21));
        send(r_type_word(F7_ALT, 20, 16, F_SR, 22));
        send(r_type_word(0, 1, 13, F_SLT, 23));
        send(r_type_word(0, 1, 13, F_SLTU, 24));
        send(r_type_word(0, 13, 1, F_SLT, 25));
        send(r_type_word(0, 13, 1, F_SLTU, 26));
        send(i_type_word(0, 11, F_SLT, 27));
        send(i_type_word(-1, 1, F_SLTU, 28));
        send(i_type_word(1, 11, F_SLTU, 29));
        send(i_type_word(-1, 13, F_SLT, 30));
        send(r_type_word(0, 11, 11, F_SLT, 31));
        idle(2);
    endtask

    task automatic x0_writes();
        send(i_type_word(55, 1, F_ADD, 0));
        send(r_type_word(0, 3, 2, F_ADD, 0));
        send(r_type_word(F7_ALT, 1, 3, F_ADD, 0));
        send(r_type_word(0, 0, 0, F_ADD, 30));
        send(i_type_word(9, 0, F_ADD, 30));
        idle(2);
    endtask

    task automatic trap_cases();
        send(32'h0000_0073);
        send(32'h0010_0073);
        send({20'hABCDE, 5'd5, 7'b0110111});
        send(32'h0000_0000);
        send(r_type_word(1, 2, 1, F_ADD, 6));
        send(r_type_word(F7_ALT, 2, 1, F_XOR, 7));
        send(32'h3020_0073);
        idle(2);
        // Registers named by the traps keep their contents
        send(r_type_word(0, 0, 5, F_ADD, 8));
        send(r_type_word(0, 0, 6, F_ADD, 9));
        send(r_type_word(0, 0, 7, F_ADD, 10));
        idle(2);
    endtask

    task automatic random_mix();
        for (int n = 0; n < N_RANDOM; n++) begin
            send(random_inst());
            if ($urandom_range(0, 4) == 0) begin
                idle($urandom_range(1, 3));
            end
        end
    endtask

    ////////////////////////////////////////
    // Compare process and watchdog
    ////////////////////////////////////////

    always @(negedge aclk) begin
        if (!rst) begin
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("A retire came out with no instruction outstanding");
                end else begin
                    exp_rec = exp_q.pop_front();
                    check_value($sformatf("retire cycle of %h", exp_rec.word),
                                32'(cycle_cnt), exp_rec.due);
                    check_value($sformatf("retire_rd_wr of %h", exp_rec.word),
                                32'(retire_rd_wr), 32'(exp_rec.rd_wr));
                    check_value($sformatf("retire_rd_addr of %h", exp_rec.word),
                                32'(retire_rd_addr), 32'(exp_rec.rd));
                    check_value($sformatf("retire_rd_val of %h", exp_rec.word),
                                retire_rd_val, exp_rec.val);
                    check_value($sformatf("status of %h", exp_rec.word),
                                32'(status), 32'(exp_rec.status));
                end
            end else begin
                check_value("retire_rd_wr while idle", 32'(retire_rd_wr), 32'd0);
                check_value("status while idle", 32'(status), 32'd0);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before all instructions retired");
    end

    initial begin
        void'($urandom(32'h3dc3));
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge aclk);
        #1;
        rst = 1'b0;

        reset_state_reads();
        dependent_chain();
        shifts_and_compares();
        x0_writes();
        trap_cases();
        random_mix();

        idle(1);
        // The last retire is due two cycles after it was driven
        repeat (4) @(negedge aclk);
        if (exp_q.size() != 0) begin
            abort_run("Instructions were still outstanding at the end of the run");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+src
src/rv32_isa_pkg.sv
src/rv32_core_pkg.sv
src/rv32_issue_if.sv
src/rv32_decoder.sv
src/rv32_registers.sv
src/rv32_alu.sv
src/rv32_core.sv
verif/rv32_core_tb.sv

//--- Makefile
# Verilator build and run for the RV32 execution core

VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF '$(PASS_MSG)'; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
